//--- rtl/gmii_tx_pkg.sv
package gmii_tx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [63:0] word_t;
    typedef logic [15:0] len_t;
    typedef logic [31:0] fcs_t;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    // preamble bytes before the SFD
    localparam int unsigned PREAMBLE_LEN = 7;
    localparam int unsigned FCS_LEN      = 4;

    // 802.3x pause frame, FCS excluded
    localparam int unsigned PAUSE_FRAME_LEN = 60;
    // DA, palr, paur, opd; the rest is padding
    localparam int unsigned PAUSE_HDR_LEN   = 18;

    localparam int unsigned BYTES_PER_WORD = 8;

    // reserved MAC control multicast address
    localparam logic [47:0] PAUSE_DA = 48'h01_80_C2_00_00_01;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_sfd,
        st_frame,
        st_fcs,
        st_ipg
    } tx_state_e;

    typedef enum logic [1:0] {
        kind_data,
        kind_pause,
        kind_pause_zero
    } frame_kind_e;

endpackage

//--- rtl/crc32_d8.sv
`timescale 1ns/10ps

module crc32_d8 (
    input  logic                tx_clk,
    input  logic                rst_n,
    input  logic                crc_init,
    input  logic                crc_en,
    input  gmii_tx_pkg::byte_t  data,
    output gmii_tx_pkg::fcs_t   fcs
);

    // reflected form of 0x04C11DB7
    localparam gmii_tx_pkg::fcs_t POLY = 32'hEDB8_8320;

    gmii_tx_pkg::fcs_t crc_q;

    // one byte, lsb first
    function automatic gmii_tx_pkg::fcs_t crc_byte(
        input gmii_tx_pkg::fcs_t  crc_in,
        input gmii_tx_pkg::byte_t d
    );
        gmii_tx_pkg::fcs_t c;
        c = crc_in ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= '1;
        end else if (crc_init) begin
            crc_q <= '1;
        end else if (crc_en) begin
            crc_q <= crc_byte(crc_q, data);
        end
    end

    // complemented register is the FCS, byte 0 goes out first
    assign fcs = ~crc_q;

endmodule

//--- rtl/payload_unpacker.sv
`timescale 1ns/10ps

module payload_unpacker (
    input  logic                tx_clk,
    input  logic                rst_n,
    input  logic                ether_en,
    input  logic                byte_take,
    input  logic                frame_end,
    input  gmii_tx_pkg::word_t  data_fifo_rdata,
    output gmii_tx_pkg::byte_t  data_byte,
    output logic                data_fifo_pop
);

    localparam int unsigned LANE_W    = $clog2(gmii_tx_pkg::BYTES_PER_WORD);
    localparam int unsigned LAST_LANE = gmii_tx_pkg::BYTES_PER_WORD - 1;

    logic [LANE_W-1:0] lane;
    logic              word_done;

    // head word is valid as long as the frame lasts
    assign data_byte = data_fifo_rdata[8*lane +: 8];

    // pop after the top lane, or early when the frame stops mid-word
    assign word_done     = (lane == LANE_W'(LAST_LANE)) || frame_end;
    assign data_fifo_pop = byte_take && word_done;

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            lane <= '0;
        end else if (!ether_en) begin
            lane <= '0;
        end else if (byte_take) begin
            if (word_done) begin
                // next frame begins on a fresh word
                lane <= '0;
            end else begin
                lane <= lane + 1'b1;
            end
        end
    end

endmodule

//--- rtl/pause_frame_gen.sv
`timescale 1ns/10ps

module pause_frame_gen (
    input  logic                      tx_clk,
    input  logic                      rst_n,
    input  logic                      frame_start,
    input  logic                      byte_take,
    input  gmii_tx_pkg::frame_kind_e  frame_kind,
    input  logic [31:0]               palr,
    input  logic [31:0]               paur,
    input  logic [31:0]               opd,
    output gmii_tx_pkg::byte_t        pause_byte
);

    localparam int unsigned HDR_LEN  = gmii_tx_pkg::PAUSE_HDR_LEN;
    localparam int unsigned HDR_BITS = 8 * HDR_LEN;

    logic [5:0]          cnt;
    logic [31:0]         opd_eff;
    logic [HDR_BITS-1:0] hdr;

    // zero quanta clears the pause time field
    assign opd_eff = (frame_kind == gmii_tx_pkg::kind_pause_zero) ?
                     {opd[31:16], 16'h0000} : opd;

    // first byte on the wire sits in the top bits
    assign hdr = {gmii_tx_pkg::PAUSE_DA, palr, paur, opd_eff};

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (frame_start) begin
            cnt <= '0;
        end else if (byte_take) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_comb begin
        if (int'(cnt) < HDR_LEN) begin
            pause_byte = hdr[8*(HDR_LEN - 1 - int'(cnt)) +: 8];
        end else begin
            // padding up to the minimum frame size
            pause_byte = 8'h00;
        end
    end

endmodule

//--- rtl/tx_sequencer.sv
`timescale 1ns/10ps

module tx_sequencer #(
    parameter int unsigned IPG_CYCLES = 12
) (
    input  logic                      tx_clk,
    input  logic                      rst_n,
    input  logic                      ether_en,
    input  logic                      tx_stop,
    input  logic                      pause_send,
    input  logic                      pause_zero_send,
    input  logic [5:0]                desc_count,
    input  gmii_tx_pkg::len_t         desc_len,
    input  gmii_tx_pkg::byte_t        data_byte,
    input  gmii_tx_pkg::byte_t        pause_byte,
    input  gmii_tx_pkg::fcs_t         fcs,
    output gmii_tx_pkg::byte_t        gmii_txd,
    output logic                      gmii_tx_en,
    output logic                      gmii_tx_er,
    output logic                      desc_pop,
    output logic                      byte_take,
    output logic                      data_take,
    output logic                      frame_end,
    output logic                      frame_start,
    output logic                      crc_init,
    output logic                      crc_en,
    output gmii_tx_pkg::byte_t        crc_data,
    output logic                      pause_done,
    output logic                      pause_zero_done,
    output logic                      tx_idle,
    output gmii_tx_pkg::frame_kind_e  frame_kind
);

    gmii_tx_pkg::tx_state_e state;
    logic [15:0]            phase;
    gmii_tx_pkg::len_t      frame_len;
    gmii_tx_pkg::byte_t     src_byte;
    logic                   last_byte;

    assign src_byte = (frame_kind == gmii_tx_pkg::kind_data) ? data_byte : pause_byte;

    assign byte_take = (state == gmii_tx_pkg::st_frame);
    assign last_byte = byte_take && (phase == frame_len - 16'd1);
    assign data_take = byte_take && (frame_kind == gmii_tx_pkg::kind_data);
    assign frame_end = data_take && last_byte;
    assign desc_pop  = frame_end;

    assign pause_done      = last_byte && (frame_kind == gmii_tx_pkg::kind_pause);
    assign pause_zero_done = last_byte && (frame_kind == gmii_tx_pkg::kind_pause_zero);

    // pause counter clears on the edge that enters st_sfd
    assign frame_start = (state == gmii_tx_pkg::st_preamble) &&
                         (phase == 16'(gmii_tx_pkg::PREAMBLE_LEN - 1));
    assign crc_init    = (state == gmii_tx_pkg::st_sfd);

    // crc absorbs the byte on the same edge it is registered to gmii_txd
    assign crc_en   = byte_take;
    assign crc_data = src_byte;

    assign tx_idle    = (state == gmii_tx_pkg::st_idle);
    assign gmii_tx_er = 1'b0;

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= gmii_tx_pkg::st_idle;
            phase      <= '0;
            frame_kind <= gmii_tx_pkg::kind_data;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else if (!ether_en) begin
            state      <= gmii_tx_pkg::st_idle;
            phase      <= '0;
            frame_kind <= gmii_tx_pkg::kind_data;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                gmii_tx_pkg::st_idle: begin
                    // pause requests win over queued data
                    if (pause_send || pause_zero_send ||
                        ((desc_count != 6'd0) && !tx_stop)) begin
                        if (pause_send) begin
                            frame_kind <= gmii_tx_pkg::kind_pause;
                        end else if (pause_zero_send) begin
                            frame_kind <= gmii_tx_pkg::kind_pause_zero;
                        end else begin
                            frame_kind <= gmii_tx_pkg::kind_data;
                        end
                        gmii_txd   <= gmii_tx_pkg::PREAMBLE_BYTE;
                        gmii_tx_en <= 1'b1;
                        phase      <= 16'd1;
                        state      <= gmii_tx_pkg::st_preamble;
                    end
                end
                gmii_tx_pkg::st_preamble: begin
                    gmii_txd <= gmii_tx_pkg::PREAMBLE_BYTE;
                    if (frame_start) begin
                        state <= gmii_tx_pkg::st_sfd;
                    end else begin
                        phase <= phase + 16'd1;
                    end
                end
                gmii_tx_pkg::st_sfd: begin
                    gmii_txd <= gmii_tx_pkg::SFD_BYTE;
                    phase    <= '0;
                    state    <= gmii_tx_pkg::st_frame;
                end
                gmii_tx_pkg::st_frame: begin
                    gmii_txd <= src_byte;
                    if (last_byte) begin
                        phase <= '0;
                        state <= gmii_tx_pkg::st_fcs;
                    end else begin
                        phase <= phase + 16'd1;
                    end
                end
                gmii_tx_pkg::st_fcs: begin
                    if (phase == 16'(gmii_tx_pkg::FCS_LEN)) begin
                        // last fcs byte is on the wire now
                        gmii_txd   <= '0;
                        gmii_tx_en <= 1'b0;
                        phase      <= '0;
                        state      <= gmii_tx_pkg::st_ipg;
                    end else begin
                        gmii_txd <= fcs[8*phase[1:0] +: 8];
                        phase    <= phase + 16'd1;
                    end
                end
                gmii_tx_pkg::st_ipg: begin
                    if (phase == 16'(IPG_CYCLES - 1)) begin
                        phase <= '0;
                        state <= gmii_tx_pkg::st_idle;
                    end else begin
                        phase <= phase + 16'd1;
                    end
                end
                default: begin
                    state <= gmii_tx_pkg::st_idle;
                end
            endcase
        end
    end

    // length is taken from the descriptor head when the frame starts
    always_ff @(posedge tx_clk) begin
        if (state == gmii_tx_pkg::st_idle) begin
            if (pause_send || pause_zero_send) begin
                frame_len <= 16'(gmii_tx_pkg::PAUSE_FRAME_LEN);
            end else begin
                frame_len <= desc_len;
            end
        end
    end

endmodule

//--- rtl/gmii_tx.sv
`timescale 1ns/10ps

module gmii_tx #(
    parameter int unsigned IPG_CYCLES = 12
) (
    input  logic                tx_clk,
    input  logic                rst_n,
    input  logic                ether_en,
    input  logic                tx_stop,
    input  logic                pause_send,
    input  logic                pause_zero_send,
    input  logic [31:0]         palr,
    input  logic [31:0]         paur,
    input  logic [31:0]         opd,
    input  logic [7:0]          data_fifo_count,
    input  gmii_tx_pkg::word_t  data_fifo_rdata,
    input  logic [5:0]          desc_count,
    input  gmii_tx_pkg::len_t   desc_len,
    output logic                data_fifo_pop,
    output logic                desc_pop,
    output logic                pause_done,
    output logic                pause_zero_done,
    output logic                tx_idle,
    output logic                gmii_tx_en,
    output logic                gmii_tx_er,
    output gmii_tx_pkg::byte_t  gmii_txd
);

    gmii_tx_pkg::byte_t       data_byte;
    gmii_tx_pkg::byte_t       pause_byte;
    gmii_tx_pkg::byte_t       crc_data;
    gmii_tx_pkg::fcs_t        fcs;
    gmii_tx_pkg::frame_kind_e frame_kind;
    logic                     byte_take;
    logic                     data_take;
    logic                     frame_end;
    logic                     frame_start;
    logic                     crc_init;
    logic                     crc_en;

    // store and forward, the words are already queued; count is not consulted
    payload_unpacker u_payload_unpacker (
        .tx_clk          (tx_clk),
        .rst_n           (rst_n),
        .ether_en        (ether_en),
        .byte_take       (data_take),
        .frame_end       (frame_end),
        .data_fifo_rdata (data_fifo_rdata),
        .data_byte       (data_byte),
        .data_fifo_pop   (data_fifo_pop)
    );

    pause_frame_gen u_pause_frame_gen (
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .byte_take   (byte_take),
        .frame_kind  (frame_kind),
        .palr        (palr),
        .paur        (paur),
        .opd         (opd),
        .pause_byte  (pause_byte)
    );

    tx_sequencer #(
        .IPG_CYCLES (IPG_CYCLES)
    ) u_tx_sequencer (
        .tx_clk          (tx_clk),
        .rst_n           (rst_n),
        .ether_en        (ether_en),
        .tx_stop         (tx_stop),
        .pause_send      (pause_send),
        .pause_zero_send (pause_zero_send),
        .desc_count      (desc_count),
        .desc_len        (desc_len),
        .data_byte       (data_byte),
        .pause_byte      (pause_byte),
        .fcs             (fcs),
        .gmii_txd        (gmii_txd),
        .gmii_tx_en      (gmii_tx_en),
        .gmii_tx_er      (gmii_tx_er),
        .desc_pop        (desc_pop),
        .byte_take       (byte_take),
        .data_take       (data_take),
        .frame_end       (frame_end),
        .frame_start     (frame_start),
        .crc_init        (crc_init),
        .crc_en          (crc_en),
        .crc_data        (crc_data),
        .pause_done      (pause_done),
        .pause_zero_done (pause_zero_done),
        .tx_idle         (tx_idle),
        .frame_kind      (frame_kind)
    );

    crc32_d8 u_crc32_d8 (
        .tx_clk   (tx_clk),
        .rst_n    (rst_n),
        .crc_init (crc_init),
        .crc_en   (crc_en),
        .data     (crc_data),
        .fcs      (fcs)
    );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- dv/gmii_tx_chk.sv
`timescale 1ns/10ps

module gmii_tx_chk (
    input logic tx_clk,
    input logic rst_n,
    input logic gmii_tx_en,
    input logic gmii_tx_er,
    input logic tx_idle,
    input logic desc_pop,
    input logic pause_done,
    input logic pause_zero_done
);

    // no underrun path, so the error line stays low
    no_tx_er: assert property (@(posedge tx_clk) disable iff (!rst_n) !gmii_tx_er)
        else $error("gmii_tx_er went high");

    idle_not_sending: assert property (@(posedge tx_clk) disable iff (!rst_n)
        !(tx_idle && gmii_tx_en))
        else $error("tx_idle high while gmii_tx_en is high");

    desc_pop_pulse: assert property (@(posedge tx_clk) disable iff (!rst_n)
        !(desc_pop && $past(desc_pop)))
        else $error("desc_pop held for more than one cycle");

    pause_done_pulse: assert property (@(posedge tx_clk) disable iff (!rst_n)
        !(pause_done && $past(pause_done)))
        else $error("pause_done held for more than one cycle");

    zero_done_pulse: assert property (@(posedge tx_clk) disable iff (!rst_n)
        !(pause_zero_done && $past(pause_zero_done)))
        else $error("pause_zero_done held for more than one cycle");

endmodule

bind gmii_tx gmii_tx_chk u_gmii_tx_chk (
    .tx_clk          (tx_clk),
    .rst_n           (rst_n),
    .gmii_tx_en      (gmii_tx_en),
    .gmii_tx_er      (gmii_tx_er),
    .tx_idle         (tx_idle),
    .desc_pop        (desc_pop),
    .pause_done      (pause_done),
    .pause_zero_done (pause_zero_done)
);

//--- dv/gmii_tx_tb.sv
`timescale 1ns/10ps

module gmii_tx_tb;

    localparam int IPG_CYCLES     = 12;
    localparam int NUM_FRAMES     = 20;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (100 + 12 + IPG_CYCLES + 4) +
                                    4 * (60 + 12 + IPG_CYCLES + 4) + 2000;

    logic                     tx_clk;
    logic                     rst_n;
    logic                     ether_en;
    logic                     tx_stop;
    logic                     pause_send;
    logic                     pause_zero_send;
    logic [31:0]              palr;
    logic [31:0]              paur;
    logic [31:0]              opd;
    logic [7:0]               data_fifo_count;
    gmii_tx_pkg::word_t       data_fifo_rdata;
    logic [5:0]               desc_count;
    gmii_tx_pkg::len_t        desc_len;
    logic                     data_fifo_pop;
    logic                     desc_pop;
    logic                     pause_done;
    logic                     pause_zero_done;
    logic                     tx_idle;
    logic                     gmii_tx_en;
    logic                     gmii_tx_er;
    gmii_tx_pkg::byte_t       gmii_txd;

    // fifo models, expected traffic and captured bytes
    gmii_tx_pkg::word_t       data_q[$];
    int                       desc_q[$];
    gmii_tx_pkg::byte_t       exp_data_q[$];
    gmii_tx_pkg::frame_kind_e exp_kind_q[$];
    int                       exp_len_q[$];
    gmii_tx_pkg::byte_t       rx_q[$];
    gmii_tx_pkg::byte_t       ref_q[$];

    logic rst_want;
    logic en_want;
    logic stop_want;
    logic pause_want;
    logic zero_want;
    logic data_pop_seen;
    logic desc_pop_seen;
    logic en_prev;
    logic idle_prev;
    logic start_pred;
    int   seed;
    int   cycle_cnt;
    int   gap_cnt;
    int   frames_seen;
    int   data_frames_seen;
    int   pause_done_cnt;
    int   zero_done_cnt;
    int   pause_cnt;
    int   zero_cnt;

    tb_clk_gen #(.PERIOD_NS(100)) u_clk_gen (.clk(tx_clk));

    gmii_tx #(
        .IPG_CYCLES (IPG_CYCLES)
    ) UUT (
        .tx_clk          (tx_clk),
        .rst_n           (rst_n),
        .ether_en        (ether_en),
        .tx_stop         (tx_stop),
        .pause_send      (pause_send),
        .pause_zero_send (pause_zero_send),
        .palr            (palr),
        .paur            (paur),
        .opd             (opd),
        .data_fifo_count (data_fifo_count),
        .data_fifo_rdata (data_fifo_rdata),
        .desc_count      (desc_count),
        .desc_len        (desc_len),
        .data_fifo_pop   (data_fifo_pop),
        .desc_pop        (desc_pop),
        .pause_done      (pause_done),
        .pause_zero_done (pause_zero_done),
        .tx_idle         (tx_idle),
        .gmii_tx_en      (gmii_tx_en),
        .gmii_tx_er      (gmii_tx_er),
        .gmii_txd        (gmii_txd)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
            $display("Errors found");
            $fatal(1, "mismatch");
        end
    endtask

    // msb-first shift register; Ethernet sends each byte lsb first
    function automatic gmii_tx_pkg::fcs_t fcs_of_ref();
        logic [31:0] crc;
        logic [31:0] res;
        logic        fb;
        crc = 32'hFFFF_FFFF;
        foreach (ref_q[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = ref_q[i][b] ^ crc[31];
                crc = {crc[30:0], 1'b0};
                if (fb) begin
                    crc = crc ^ 32'h04C1_1DB7;
                end
            end
        end
        // bit 31 of the complement goes on the wire first
        for (int k = 0; k < 32; k++) begin
            res[k] = ~crc[31 - k];
        end
        return res;
    endfunction

    function automatic gmii_tx_pkg::byte_t pause_ref_byte(input int idx,
                                                         input gmii_tx_pkg::frame_kind_e kind);
        logic [47:0] da;
        logic [31:0] op;
        da = gmii_tx_pkg::PAUSE_DA;
        op = opd;
        if (kind == gmii_tx_pkg::kind_pause_zero) begin
            op[15:0] = 16'h0000;
        end
        if (idx < 6) begin
            return da[8*(5 - idx) +: 8];
        end else if (idx < 10) begin
            return palr[8*(9 - idx) +: 8];
        end else if (idx < 14) begin
            return paur[8*(13 - idx) +: 8];
        end else if (idx < 18) begin
            return op[8*(17 - idx) +: 8];
        end
        return 8'h00;
    endfunction

    task automatic check_frame();
        gmii_tx_pkg::frame_kind_e kind;
        gmii_tx_pkg::fcs_t        fcs;
        int                       len;
        check_value(32'(exp_kind_q.size() != 0), 32'd1, "frame sent that was never chosen");
        kind = exp_kind_q.pop_front();
        len  = exp_len_q.pop_front();
        check_value(32'(rx_q.size()), 32'(12 + len), "enable window length");
        ref_q.delete();
        for (int i = 0; i < len; i++) begin
            if (kind == gmii_tx_pkg::kind_data) begin
                ref_q.push_back(exp_data_q.pop_front());
            end else begin
                ref_q.push_back(pause_ref_byte(i, kind));
            end
        end
        fcs = fcs_of_ref();
        for (int i = 0; i < 7; i++) begin
            check_value(32'(rx_q[i]), 32'h55, $sformatf("preamble byte %0d", i));
        end
        check_value(32'(rx_q[7]), 32'hD5, "SFD byte");
        for (int i = 0; i < len; i++) begin
            check_value(32'(rx_q[8 + i]), 32'(ref_q[i]), $sformatf("frame byte %0d", i));
        end
        for (int i = 0; i < 4; i++) begin
            check_value(32'(rx_q[8 + len + i]), 32'(fcs[8*i +: 8]), $sformatf("FCS byte %0d", i));
        end
        check_value(32'(pause_done_cnt), 32'(kind == gmii_tx_pkg::kind_pause),
                    "pause_done pulses in frame");
        check_value(32'(zero_done_cnt), 32'(kind == gmii_tx_pkg::kind_pause_zero),
                    "pause_zero_done pulses in frame");
        frames_seen++;
        if (kind == gmii_tx_pkg::kind_data) begin
            data_frames_seen++;
        end
    endtask

    task automatic load_frame(input int len);
        gmii_tx_pkg::word_t w;
        gmii_tx_pkg::byte_t b;
        w = '0;
        for (int i = 0; i < len; i++) begin
            b = gmii_tx_pkg::byte_t'($random(seed));
            exp_data_q.push_back(b);
            w[8*(i % gmii_tx_pkg::BYTES_PER_WORD) +: 8] = b;
            if ((i % gmii_tx_pkg::BYTES_PER_WORD == 7) || (i == len - 1)) begin
                data_q.push_back(w);
                w = '0;
            end
        end
        // descriptor only after its words
        desc_q.push_back(len);
    endtask

    task automatic request_pause(input gmii_tx_pkg::frame_kind_e kind);
        if (kind == gmii_tx_pkg::kind_pause) begin
            while (pause_want) @(posedge tx_clk);
            pause_want = 1'b1;
            pause_cnt++;
        end else begin
            while (zero_want) @(posedge tx_clk);
            zero_want = 1'b1;
            zero_cnt++;
        end
    endtask

    always @(posedge tx_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    always @(negedge tx_clk) begin
        // a pop seen last cycle took effect at the rising edge since then
        if (data_pop_seen) begin
            check_value(32'(data_q.size() != 0), 32'd1, "data FIFO popped while empty");
            void'(data_q.pop_front());
        end
        if (desc_pop_seen) begin
            check_value(32'(desc_q.size() != 0), 32'd1, "descriptor popped while empty");
            void'(desc_q.pop_front());
        end
        data_pop_seen = data_fifo_pop;
        desc_pop_seen = desc_pop;

        if (!rst_n || !ether_en) begin
            check_value(32'({gmii_tx_en, gmii_txd, data_fifo_pop, desc_pop, pause_done,
                             pause_zero_done}), 32'd0, "outputs active in reset");
            check_value(32'(tx_idle), 32'd1, "tx_idle in reset");
        end
        check_value(32'(gmii_tx_er), 32'd0, "gmii_tx_er asserted");
        if (idle_prev) begin
            check_value(32'(gmii_tx_en), 32'(start_pred), "frame start decision");
        end

        if (pause_done) begin
            pause_want = 1'b0;
            pause_done_cnt++;
        end
        if (pause_zero_done) begin
            zero_want = 1'b0;
            zero_done_cnt++;
        end

        // monitor
        if (gmii_tx_en) begin
            if (!en_prev) begin
                if (frames_seen > 0) begin
                    check_value(32'(gap_cnt >= IPG_CYCLES), 32'd1, "inter-packet gap too short");
                end
                rx_q.delete();
                pause_done_cnt = 0;
                zero_done_cnt  = 0;
            end
            rx_q.push_back(gmii_txd);
        end else if (en_prev) begin
            check_frame();
            gap_cnt = 1;
        end else begin
            gap_cnt++;
        end
        en_prev = gmii_tx_en;

        rst_n           = rst_want;
        ether_en        = en_want;
        tx_stop         = stop_want;
        pause_send      = pause_want;
        pause_zero_send = zero_want;
        data_fifo_count = (data_q.size() > 255) ? 8'd255 : 8'(data_q.size());
        data_fifo_rdata = (data_q.size() != 0) ? data_q[0] : '0;
        desc_count      = 6'(desc_q.size());
        desc_len        = (desc_q.size() != 0) ? 16'(desc_q[0]) : '0;

        // what the next rising edge should pick, by priority
        start_pred = 1'b0;
        idle_prev  = rst_n && ether_en && tx_idle;
        if (idle_prev) begin
            if (pause_send) begin
                exp_kind_q.push_back(gmii_tx_pkg::kind_pause);
                exp_len_q.push_back(gmii_tx_pkg::PAUSE_FRAME_LEN);
                start_pred = 1'b1;
            end else if (pause_zero_send) begin
                exp_kind_q.push_back(gmii_tx_pkg::kind_pause_zero);
                exp_len_q.push_back(gmii_tx_pkg::PAUSE_FRAME_LEN);
                start_pred = 1'b1;
            end else if ((desc_q.size() != 0) && !tx_stop) begin
                exp_kind_q.push_back(gmii_tx_pkg::kind_data);
                exp_len_q.push_back(desc_q[0]);
                start_pred = 1'b1;
            end
        end
    end

    initial begin
        int          wait_cycles;
        int          len;
        logic [31:0] r;
        seed             = 32'h61b715f5;
        rst_n            = 1'b0;
        ether_en         = 1'b0;
        tx_stop          = 1'b0;
        pause_send       = 1'b0;
        pause_zero_send  = 1'b0;
        data_fifo_count  = '0;
        data_fifo_rdata  = '0;
        desc_count       = '0;
        desc_len         = '0;
        rst_want         = 1'b0;
        en_want          = 1'b0;
        stop_want        = 1'b0;
        pause_want       = 1'b0;
        zero_want        = 1'b0;
        data_pop_seen    = 1'b0;
        desc_pop_seen    = 1'b0;
        en_prev          = 1'b0;
        idle_prev        = 1'b0;
        start_pred       = 1'b0;
        cycle_cnt        = 0;
        gap_cnt          = 0;
        frames_seen      = 0;
        data_frames_seen = 0;
        pause_done_cnt   = 0;
        zero_done_cnt    = 0;
        pause_cnt        = 0;
        zero_cnt         = 0;
        palr             = $random(seed);
        paur             = $random(seed);
        opd              = $random(seed);

        repeat (16) @(posedge tx_clk);
        rst_want = 1'b1;
        repeat (4) @(posedge tx_clk);
        en_want = 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            // data held back over frames 8 to 11 while pause frames still go
            if (f == 8) begin
                stop_want = 1'b1;
            end
            if (f == 12) begin
                stop_want = 1'b0;
            end
            wait_cycles = {$random(seed)} % 64;
            repeat (wait_cycles) @(posedge tx_clk);
            r = $random(seed);
            if ((f == 9) || ((r[2:0] == 3'd0) && (pause_cnt == 0))) begin
                request_pause(gmii_tx_pkg::kind_pause);
            end
            if ((f == 10) || ((r[5:3] == 3'd0) && (zero_cnt == 0))) begin
                request_pause(gmii_tx_pkg::kind_pause_zero);
            end
            len = 14 + {$random(seed)} % 87;
            load_frame(len);
        end

        while ((desc_q.size() != 0) || pause_want || zero_want || (exp_kind_q.size() != 0)) begin
            @(posedge tx_clk);
        end
        repeat (IPG_CYCLES + 4) @(posedge tx_clk);

        check_value(32'(data_q.size()), 32'd0, "words left in the data FIFO");
        check_value(32'(exp_data_q.size()), 32'd0, "frame bytes never sent");
        check_value(32'(data_frames_seen), 32'(NUM_FRAMES), "data frames sent");
        check_value(32'(frames_seen), 32'(NUM_FRAMES + pause_cnt + zero_cnt), "frames sent");
        $display("No errors");
        $finish;
    end

endmodule

//--- compile.f
rtl/gmii_tx_pkg.sv
rtl/crc32_d8.sv
rtl/payload_unpacker.sv
rtl/pause_frame_gen.sv
rtl/tx_sequencer.sv
rtl/gmii_tx.sv
dv/tb_clk_gen.sv
dv/gmii_tx_chk.sv
dv/gmii_tx_tb.sv

//--- run.sh
#!/bin/sh
# build and run the gmii_tx testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module gmii_tx_tb -f compile.f

# the pipeline status is that of grep, so a missing pass line fails the script
./obj_dir/Vgmii_tx_tb | tee /dev/stderr | grep -x "No errors" > /dev/null

echo "simulation passed"
